/* verilog/exu_pkg.sv */
`default_nettype none

package exu_pkg;

    localparam int XLEN       = 64;
    localparam int ILEN       = 32;
    localparam int REG_IDX_W  = 5;
    localparam int ALU_TYPE_W = 11;

    // bit positions inside the one-hot alu_type vector.
    typedef enum logic [3:0] {
        ALU_ADD   = 4'd0,
        ALU_SLT   = 4'd1,  // unsigned when is_unsigned is set.
        ALU_XOR   = 4'd2,
        ALU_OR    = 4'd3,
        ALU_AND   = 4'd4,
        ALU_SLL   = 4'd5,
        ALU_SRL   = 4'd6,
        ALU_SRA   = 4'd7,
        ALU_SUB   = 4'd8,
        ALU_LUI   = 4'd9,
        ALU_AUIPC = 4'd10
    } alu_op_e;

    // major opcodes handled by the slice.
    localparam logic [6:0] OPC_OP        = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM    = 7'b0010011;
    localparam logic [6:0] OPC_OP_32     = 7'b0111011;
    localparam logic [6:0] OPC_OP_IMM_32 = 7'b0011011;
    localparam logic [6:0] OPC_LUI       = 7'b0110111;
    localparam logic [6:0] OPC_AUIPC     = 7'b0010111;

endpackage

`default_nettype wire

/* verilog/int_decode.sv */
`timescale 1ns/100ps
`default_nettype none

module int_decode import exu_pkg::*; (
    input  logic [ILEN-1:0]       instr,
    output logic [REG_IDX_W-1:0]  rs1,
    output logic [REG_IDX_W-1:0]  rs2,
    output logic [REG_IDX_W-1:0]  rd,
    output logic [XLEN-1:0]       imm,
    output logic [ALU_TYPE_W-1:0] alu_type,
    output logic                  is_word,
    output logic                  is_unsigned,
    output logic                  is_imm,
    output logic                  wr_en,
    output logic                  dec_illegal
);

    localparam logic [2:0] F3_ADD  = 3'b000;
    localparam logic [2:0] F3_SLL  = 3'b001;
    localparam logic [2:0] F3_SLT  = 3'b010;
    localparam logic [2:0] F3_SLTU = 3'b011;
    localparam logic [2:0] F3_XOR  = 3'b100;
    localparam logic [2:0] F3_SR   = 3'b101;
    localparam logic [2:0] F3_OR   = 3'b110;
    localparam logic [2:0] F3_AND  = 3'b111;

    localparam logic [6:0] F7_BASE = 7'b0000000;
    localparam logic [6:0] F7_ALT  = 7'b0100000;

    logic [6:0]      opcode;
    logic [2:0]      funct3;
    logic [6:0]      funct7;
    logic [XLEN-1:0] imm_i;
    logic [XLEN-1:0] imm_u;
    logic            alt;       // sub or sra selected.
    logic            funct_ok;
    logic            shift_ok;

    assign opcode = instr[6:0];
    assign funct3 = instr[14:12];
    assign funct7 = instr[31:25];
    assign imm_i  = {{(XLEN-12){instr[31]}}, instr[31:20]};
    assign imm_u  = {{(XLEN-32){instr[31]}}, instr[31:12], 12'b0};

    always_comb begin
        rs1         = instr[19:15];
        rs2         = instr[24:20];
        rd          = instr[11:7];
        imm         = imm_i;
        alu_type    = '0;
        is_word     = 1'b0;
        is_unsigned = 1'b0;
        is_imm      = 1'b0;
        wr_en       = 1'b1;
        dec_illegal = 1'b0;
        alt         = instr[30];
        funct_ok    = 1'b1;
        shift_ok    = 1'b1;

        case (opcode)
            OPC_OP, OPC_OP_32, OPC_OP_IMM, OPC_OP_IMM_32: begin
                is_word = (opcode == OPC_OP_32) || (opcode == OPC_OP_IMM_32);
                is_imm  = (opcode == OPC_OP_IMM) || (opcode == OPC_OP_IMM_32);

                if (is_imm) begin
                    rs2 = '0;
                    // shamt field is 6 bits wide, bit 5 is reserved in word forms.
                    shift_ok = (instr[31:26] == 6'b000000 ||
                                (funct3 == F3_SR && instr[31:26] == 6'b010000)) &&
                               !(is_word && instr[25]);
                    funct_ok = (funct3 == F3_SLL || funct3 == F3_SR) ? shift_ok : 1'b1;
                    alt      = alt && (funct3 == F3_SR);
                end else begin
                    funct_ok = (funct7 == F7_BASE) ||
                               (funct7 == F7_ALT && (funct3 == F3_ADD || funct3 == F3_SR));
                end

                // word forms only exist for add/sub and the shifts.
                if (is_word && !(funct3 == F3_ADD || funct3 == F3_SLL || funct3 == F3_SR)) begin
                    funct_ok = 1'b0;
                end
                dec_illegal = !funct_ok;

                case (funct3)
                    F3_ADD: begin
                        if (alt) begin
                            alu_type[ALU_SUB] = 1'b1;
                        end else begin
                            alu_type[ALU_ADD] = 1'b1;
                        end
                    end
                    F3_SLL:  alu_type[ALU_SLL] = 1'b1;
                    F3_SLT:  alu_type[ALU_SLT] = 1'b1;
                    F3_SLTU: begin
                        alu_type[ALU_SLT] = 1'b1;
                        is_unsigned       = 1'b1;
                    end
                    F3_XOR:  alu_type[ALU_XOR] = 1'b1;
                    F3_SR: begin
                        if (alt) begin
                            alu_type[ALU_SRA] = 1'b1;
                        end else begin
                            alu_type[ALU_SRL] = 1'b1;
                        end
                    end
                    F3_OR:   alu_type[ALU_OR] = 1'b1;
                    F3_AND:  alu_type[ALU_AND] = 1'b1;
                    default: dec_illegal = 1'b1;
                endcase
            end
            OPC_LUI: begin
                rs1               = '0;
                rs2               = '0;
                imm               = imm_u;
                is_imm            = 1'b1;
                alu_type[ALU_LUI] = 1'b1;
            end
            OPC_AUIPC: begin
                rs1                 = '0;
                rs2                 = '0;
                imm                 = imm_u;
                is_imm              = 1'b1;
                alu_type[ALU_AUIPC] = 1'b1;
            end
            default: dec_illegal = 1'b1;
        endcase

        if (dec_illegal) begin
            alu_type    = '0;  // rejected encodings have no effect.
            is_unsigned = 1'b0;
            wr_en       = 1'b0;
        end
    end

endmodule

`default_nettype wire

/* verilog/regfile.sv */
`timescale 1ns/100ps
`default_nettype none

module regfile import exu_pkg::*; #(
    parameter int XLEN_REGS = 32
) (
    input  logic                 clock,
    input  logic                 rst_n,
    input  logic [REG_IDX_W-1:0] raddr1,
    input  logic [REG_IDX_W-1:0] raddr2,
    output logic [XLEN-1:0]      rdata1,
    output logic [XLEN-1:0]      rdata2,
    input  logic                 we,
    input  logic [REG_IDX_W-1:0] waddr,
    input  logic [XLEN-1:0]      wdata
);

    // x0 has no storage.
    logic [XLEN-1:0] regs [1:XLEN_REGS-1];

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 1; i < XLEN_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (we && waddr != '0 && waddr < XLEN_REGS) begin
            regs[waddr] <= wdata;
        end
    end

    assign rdata1 = (raddr1 == '0 || raddr1 >= XLEN_REGS) ? '0 : regs[raddr1];
    assign rdata2 = (raddr2 == '0 || raddr2 >= XLEN_REGS) ? '0 : regs[raddr2];

endmodule

`default_nettype wire

/* verilog/alu.sv */
`timescale 1ns/100ps
`default_nettype none

module alu import exu_pkg::*; (
    input  logic [XLEN-1:0]       src1,
    input  logic [XLEN-1:0]       src2,
    input  logic [XLEN-1:0]       imm,
    input  logic [XLEN-1:0]       pc,
    input  logic                  valid,
    input  logic [ALU_TYPE_W-1:0] alu_type,
    input  logic                  is_word,
    input  logic                  is_unsigned,
    input  logic                  is_imm,
    output logic [XLEN-1:0]       result
);

    function automatic logic [XLEN-1:0] sext_w(input logic [31:0] v);
        return {{(XLEN-32){v[31]}}, v};
    endfunction

    logic [XLEN-1:0] op2;
    logic [XLEN-1:0] sum;
    logic [XLEN-1:0] diff;
    logic [31:0]     sum_w;
    logic [31:0]     diff_w;
    logic            lt_s;
    logic            lt_u;
    logic [XLEN-1:0] sll_d;
    logic [XLEN-1:0] srl_d;
    logic [XLEN-1:0] sra_d;
    logic [31:0]     sll_w;
    logic [31:0]     srl_w;
    logic [31:0]     sra_w;
    logic [XLEN-1:0] res_sel;

    assign op2 = is_imm ? imm : src2;

    assign sum    = src1 + op2;
    assign diff   = src1 - op2;
    assign sum_w  = src1[31:0] + op2[31:0];
    assign diff_w = src1[31:0] - op2[31:0];

    assign lt_s = $signed(src1) < $signed(op2);
    assign lt_u = src1 < op2;

    // full width shifts take a 6-bit amount, word shifts 5 bits.
    assign sll_d = src1 << op2[5:0];
    assign srl_d = src1 >> op2[5:0];
    assign sra_d = $signed(src1) >>> op2[5:0];
    assign sll_w = src1[31:0] << op2[4:0];
    assign srl_w = src1[31:0] >> op2[4:0];
    assign sra_w = $signed(src1[31:0]) >>> op2[4:0];

    always_comb begin
        res_sel = '0;
        if (alu_type[ALU_ADD]) begin
            res_sel = is_word ? sext_w(sum_w) : sum;
        end
        if (alu_type[ALU_SUB]) begin
            res_sel = is_word ? sext_w(diff_w) : diff;
        end
        if (alu_type[ALU_SLT]) begin
            res_sel = {{(XLEN-1){1'b0}}, is_unsigned ? lt_u : lt_s};
        end
        if (alu_type[ALU_XOR]) begin
            res_sel = src1 ^ op2;
        end
        if (alu_type[ALU_OR]) begin
            res_sel = src1 | op2;
        end
        if (alu_type[ALU_AND]) begin
            res_sel = src1 & op2;
        end
        if (alu_type[ALU_SLL]) begin
            res_sel = is_word ? sext_w(sll_w) : sll_d;
        end
        if (alu_type[ALU_SRL]) begin
            res_sel = is_word ? sext_w(srl_w) : srl_d;
        end
        if (alu_type[ALU_SRA]) begin
            res_sel = is_word ? sext_w(sra_w) : sra_d;
        end
        if (alu_type[ALU_LUI]) begin
            res_sel = imm;
        end
        if (alu_type[ALU_AUIPC]) begin
            res_sel = pc + imm;
        end
    end

    assign result = valid ? res_sel : '0;  // idle stage gives zero.

endmodule

`default_nettype wire

/* verilog/int_exu.sv */
`timescale 1ns/100ps
`default_nettype none

module int_exu import exu_pkg::*; #(
    parameter int XLEN_REGS = 32
) (
    input  logic                 clock,
    input  logic                 rst_n,
    input  logic                 instr_valid,
    input  logic [ILEN-1:0]      instr,
    input  logic [XLEN-1:0]      pc,
    output logic                 wb_valid,
    output logic [REG_IDX_W-1:0] wb_rd,
    output logic [XLEN-1:0]      wb_data,
    output logic                 illegal
);

    logic [REG_IDX_W-1:0]  dec_rs1;
    logic [REG_IDX_W-1:0]  dec_rs2;
    logic [REG_IDX_W-1:0]  dec_rd;
    logic [XLEN-1:0]       dec_imm;
    logic [ALU_TYPE_W-1:0] dec_alu_type;
    logic                  dec_is_word;
    logic                  dec_is_unsigned;
    logic                  dec_is_imm;
    logic                  dec_wr_en;
    logic                  dec_illegal;

    logic [XLEN-1:0] rf_rdata1;
    logic [XLEN-1:0] rf_rdata2;
    logic            ex_hit1;
    logic            ex_hit2;
    logic            wb_hit1;
    logic            wb_hit2;
    logic [XLEN-1:0] opnd1;
    logic [XLEN-1:0] opnd2;

    logic                  ex_valid;
    logic [REG_IDX_W-1:0]  ex_rd;
    logic [XLEN-1:0]       ex_src1;
    logic [XLEN-1:0]       ex_src2;
    logic [XLEN-1:0]       ex_imm;
    logic [XLEN-1:0]       ex_pc;
    logic [ALU_TYPE_W-1:0] ex_alu_type;
    logic                  ex_is_word;
    logic                  ex_is_unsigned;
    logic                  ex_is_imm;
    logic [XLEN-1:0]       alu_result;

    int_decode u_decode (
        .instr       (instr),
        .rs1         (dec_rs1),
        .rs2         (dec_rs2),
        .rd          (dec_rd),
        .imm         (dec_imm),
        .alu_type    (dec_alu_type),
        .is_word     (dec_is_word),
        .is_unsigned (dec_is_unsigned),
        .is_imm      (dec_is_imm),
        .wr_en       (dec_wr_en),
        .dec_illegal (dec_illegal)
    );

    regfile #(
        .XLEN_REGS (XLEN_REGS)
    ) u_regfile (
        .clock  (clock),
        .rst_n  (rst_n),
        .raddr1 (dec_rs1),
        .raddr2 (dec_rs2),
        .rdata1 (rf_rdata1),
        .rdata2 (rf_rdata2),
        .we     (wb_valid),
        .waddr  (wb_rd),
        .wdata  (wb_data)
    );

    // forwarding, the youngest producer wins.
    assign ex_hit1 = ex_valid && ex_rd != '0 && ex_rd == dec_rs1;
    assign ex_hit2 = ex_valid && ex_rd != '0 && ex_rd == dec_rs2;
    assign wb_hit1 = wb_valid && wb_rd != '0 && wb_rd == dec_rs1;
    assign wb_hit2 = wb_valid && wb_rd != '0 && wb_rd == dec_rs2;

    assign opnd1 = ex_hit1 ? alu_result : (wb_hit1 ? wb_data : rf_rdata1);
    assign opnd2 = ex_hit2 ? alu_result : (wb_hit2 ? wb_data : rf_rdata2);

    // execute stage register.
    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            ex_valid    <= 1'b0;
            ex_alu_type <= '0;
            illegal     <= 1'b0;
        end else begin
            ex_valid    <= instr_valid && dec_wr_en;
            ex_alu_type <= instr_valid ? dec_alu_type : '0;
            illegal     <= instr_valid && dec_illegal;
        end
    end

    always_ff @(posedge clock) begin
        ex_rd          <= dec_rd;
        ex_src1        <= opnd1;
        ex_src2        <= opnd2;
        ex_imm         <= dec_imm;
        ex_pc          <= pc;
        ex_is_word     <= dec_is_word;
        ex_is_unsigned <= dec_is_unsigned;
        ex_is_imm      <= dec_is_imm;
    end

    alu u_alu (
        .src1        (ex_src1),
        .src2        (ex_src2),
        .imm         (ex_imm),
        .pc          (ex_pc),
        .valid       (ex_valid),
        .alu_type    (ex_alu_type),
        .is_word     (ex_is_word),
        .is_unsigned (ex_is_unsigned),
        .is_imm      (ex_is_imm),
        .result      (alu_result)
    );

    // writeback register, also the write port of the register file.
    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            wb_valid <= 1'b0;
        end else begin
            wb_valid <= ex_valid;
        end
    end

    always_ff @(posedge clock) begin
        wb_rd   <= ex_rd;
        wb_data <= alu_result;
    end

endmodule

`default_nettype wire

/* test/int_exu_check.sv */
`timescale 1ns/100ps
`default_nettype none

module int_exu_check import exu_pkg::*; (
    input  logic                 clock,
    input  logic                 rst_n,
    input  logic                 instr_valid,
    input  logic [ILEN-1:0]      instr,
    input  logic [XLEN-1:0]      pc,
    input  logic                 wb_valid,
    input  logic [REG_IDX_W-1:0] wb_rd,
    input  logic [XLEN-1:0]      wb_data,
    input  logic                 illegal,
    output int                   errors,
    output int                   checked,
    output int                   pending
);

    logic [XLEN-1:0]      shadow [0:31];  // entry 0 is never written.
    logic [XLEN-1:0]      exp_data_q [$];
    logic [REG_IDX_W-1:0] exp_rd_q [$];
    int                   exp_cyc_q [$];
    int                   ill_cyc_q [$];
    int                   cyc;
    int                   c;
    logic [XLEN-1:0]      d;
    logic [REG_IDX_W-1:0] r;

    function automatic logic ref_legal(input logic [31:0] ins);
        logic [2:0] f3;
        logic [6:0] f7;
        f3 = ins[14:12];
        f7 = ins[31:25];
        case (ins[6:0])
            OPC_LUI, OPC_AUIPC: return 1'b1;
            OPC_OP: return f7 == 7'h00 || (f7 == 7'h20 && (f3 == 3'd0 || f3 == 3'd5));
            OPC_OP_32: return (f3 == 3'd0 || f3 == 3'd1 || f3 == 3'd5) &&
                              (f7 == 7'h00 || (f7 == 7'h20 && f3 != 3'd1));
            OPC_OP_IMM: begin
                if (f3 == 3'd1) return ins[31:26] == 6'h00;
                if (f3 == 3'd5) return ins[31:26] == 6'h00 || ins[31:26] == 6'h10;
                return 1'b1;
            end
            OPC_OP_IMM_32: begin
                if (f3 == 3'd0) return 1'b1;
                if (f3 == 3'd1) return f7 == 7'h00;
                if (f3 == 3'd5) return f7 == 7'h00 || f7 == 7'h20;
                return 1'b0;
            end
            default: return 1'b0;
        endcase
    endfunction

    // expected result of one legal instruction by the ISA rules.
    function automatic logic [63:0] ref_alu(input logic [31:0] ins, input logic [63:0] ipc,
                                            input logic [63:0] a, input logic [63:0] b);
        logic [63:0]        immi;
        logic [63:0]        immu;
        logic [63:0]        y;
        logic [63:0]        res;
        logic signed [31:0] aw;
        logic               word;
        logic               use_imm;
        logic               alt;
        immi    = {{52{ins[31]}}, ins[31:20]};
        immu    = {{32{ins[31]}}, ins[31:12], 12'h000};
        word    = ins[6:0] == OPC_OP_32 || ins[6:0] == OPC_OP_IMM_32;
        use_imm = ins[6:0] == OPC_OP_IMM || ins[6:0] == OPC_OP_IMM_32;
        alt     = ins[30];
        aw      = a[31:0];
        y       = use_imm ? immi : b;
        if (ins[6:0] == OPC_LUI) return immu;
        if (ins[6:0] == OPC_AUIPC) return ipc + immu;
        case (ins[14:12])
            3'd0: res = (alt && !use_imm) ? a - y : a + y;
            3'd1: res = word ? a << y[4:0] : a << y[5:0];
            3'd2: res = {63'd0, $signed(a) < $signed(y)};
            3'd3: res = {63'd0, a < y};
            3'd4: res = a ^ y;
            3'd5: begin
                if (word) res = alt ? {32'd0, aw >>> y[4:0]} : {32'd0, a[31:0] >> y[4:0]};
                else if (alt) res = $signed(a) >>> y[5:0];
                else res = a >> y[5:0];
            end
            3'd6: res = a | y;
            default: res = a & y;
        endcase
        if (word) res = {{32{res[31]}}, res[31:0]};
        return res;
    endfunction

    initial begin
        errors  = 0;
        checked = 0;
        pending = 0;
        cyc     = 0;
        for (int i = 0; i < 32; i++) shadow[i] = '0;
    end

    always @(posedge clock) begin
        cyc = cyc + 1;
        if (!rst_n) begin
            if (wb_valid || illegal) begin
                $display("output strobe seen while reset is held");
                errors = errors + 1;
            end
        end else begin
            if (wb_valid) begin
                if (exp_cyc_q.size() == 0) begin
                    $display("writeback seen with no legal instruction outstanding");
                    errors = errors + 1;
                end else begin
                    c = exp_cyc_q.pop_front();
                    d = exp_data_q.pop_front();
                    r = exp_rd_q.pop_front();
                    checked = checked + 1;
                    if (cyc != c + 2) begin
                        $display("writeback arrived %0d edges after its strobe", cyc - c);
                        errors = errors + 1;
                    end
                    if (wb_rd != r || wb_data != d) begin
                        $display("error %0t: wb x%0d=%h, expected x%0d=%h", $time,
                                 wb_rd, wb_data, r, d);
                        errors = errors + 1;
                    end
                end
            end
            if (illegal) begin
                if (ill_cyc_q.size() == 0 || ill_cyc_q.pop_front() != cyc - 1) begin
                    $display("illegal pulse without a matching illegal instruction");
                    errors = errors + 1;
                end
            end
            // timeout for results that never came.
            if (exp_cyc_q.size() != 0 && exp_cyc_q[0] + 2 < cyc) begin
                $display("writeback missing for an instruction issued at edge %0d", exp_cyc_q[0]);
                void'(exp_cyc_q.pop_front());
                void'(exp_data_q.pop_front());
                void'(exp_rd_q.pop_front());
                errors = errors + 1;
            end
            if (ill_cyc_q.size() != 0 && ill_cyc_q[0] + 1 < cyc) begin
                $display("illegal pulse missing for a rejected instruction");
                void'(ill_cyc_q.pop_front());
                errors = errors + 1;
            end
            if (instr_valid) begin
                if (ref_legal(instr)) begin
                    d = ref_alu(instr, pc, shadow[instr[19:15]], shadow[instr[24:20]]);
                    exp_cyc_q.push_back(cyc);
                    exp_data_q.push_back(d);
                    exp_rd_q.push_back(instr[11:7]);
                    if (instr[11:7] != 5'd0) shadow[instr[11:7]] = d;
                end else begin
                    ill_cyc_q.push_back(cyc);
                end
            end
        end
        pending = exp_cyc_q.size() + ill_cyc_q.size();
    end

endmodule

`default_nettype wire

/* test/int_exu_assert.sv */
`timescale 1ns/100ps
`default_nettype none

module int_exu_assert (
    input logic clock,
    input logic rst_n,
    input logic instr_valid,
    input logic wb_valid,
    input logic illegal
);

    // a rejected instruction never reaches writeback.
    a_illegal_no_wb: assert property (@(posedge clock) disable iff (!rst_n)
        illegal |=> !wb_valid)
        else $error("wb_valid one cycle after an illegal pulse");

    a_quiet_in_reset: assert property (@(posedge clock) !rst_n |-> !wb_valid)
        else $error("wb_valid high during reset");

    // two edges from strobe to result.
    a_wb_latency: assert property (@(posedge clock) disable iff (!rst_n)
        wb_valid |-> $past(instr_valid, 2))
        else $error("wb_valid without a strobe two edges earlier");

endmodule

bind int_exu int_exu_assert u_assert (.*);

`default_nettype wire

/* test/int_exu_tb.sv */
`timescale 1ns/100ps
`default_nettype none

module int_exu_tb import exu_pkg::*; ();

    logic                 clock;
    logic                 rst_n;
    logic                 instr_valid;
    logic [ILEN-1:0]      instr;
    logic [XLEN-1:0]      pc;
    logic                 wb_valid;
    logic [REG_IDX_W-1:0] wb_rd;
    logic [XLEN-1:0]      wb_data;
    logic                 illegal;
    int                   errors;
    int                   checked;
    int                   pending;
    logic [31:0]          seed;
    int                   issued;
    int                   wait_cyc;
    logic                 timed_out;

    int_exu #(.XLEN_REGS(32)) dut0 (.*);
    int_exu_check chk0 (.*);

    always #10 clock = ~clock;

    function automatic logic [31:0] lcg(input logic [31:0] s);
        return s * 32'd1103515245 + 32'd12345;
    endfunction

    task automatic make_instr(output logic [31:0] ins);
        logic [2:0]  f3;
        logic [2:0]  f3w;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [4:0]  rd;
        logic [11:0] im;
        logic        alt;
        logic [2:0]  kind;
        seed = lcg(seed);
        f3   = seed[18:16];
        rs1  = {2'b00, seed[21:19]};  // few registers, many dependencies.
        rs2  = {2'b00, seed[24:22]};
        rd   = {2'b00, seed[27:25]};
        alt  = seed[28];
        kind = seed[31:29];
        f3w  = (f3[1:0] == 2'd0) ? 3'd0 : ((f3[1:0] == 2'd1) ? 3'd1 : 3'd5);
        seed = lcg(seed);
        im   = seed[27:16];
        case (kind)
            3'd0, 3'd1: ins = {(alt && (f3 == 3'd0 || f3 == 3'd5)) ? 7'h20 : 7'h00,
                               rs2, rs1, f3, rd, OPC_OP};
            3'd2: ins = {(alt && f3w != 3'd1) ? 7'h20 : 7'h00, rs2, rs1, f3w, rd, OPC_OP_32};
            3'd3, 3'd4: begin
                if (f3 == 3'd1) im[11:6] = 6'h00;
                if (f3 == 3'd5) im[11:6] = alt ? 6'h10 : 6'h00;
                ins = {im, rs1, f3, rd, OPC_OP_IMM};
            end
            3'd5: begin
                if (f3w != 3'd0) im[11:5] = (alt && f3w == 3'd5) ? 7'h20 : 7'h00;
                ins = {im, rs1, f3w, rd, OPC_OP_IMM_32};
            end
            3'd6: ins = {im, seed[23:16], rd, OPC_LUI};
            default: ins = {im, seed[23:16], rd, OPC_AUIPC};
        endcase
        seed = lcg(seed);
        if (seed[30:16] % 30 == 0) ins = {ins[31:7], 7'b1100011};  // branch, rejected.
    endtask

    initial begin
        clock       = 1'b0;
        rst_n       = 1'b0;
        instr_valid = 1'b1;  // strobes during reset must not reach writeback.
        instr       = {12'd1, 5'd0, 3'd0, 5'd1, OPC_OP_IMM};
        pc          = 64'h8000_0000;
        seed        = 32'd33;
        issued      = 0;
        timed_out   = 1'b0;
        repeat (4) @(posedge clock);
        @(negedge clock);
        rst_n       = 1'b1;
        instr_valid = 1'b0;
        while (issued < 400) begin
            @(negedge clock);
            seed = lcg(seed);
            if (seed[18:16] == 3'd0) begin
                instr_valid = 1'b0;  // idle slot.
            end else begin
                make_instr(instr);
                pc          = pc + 64'd4;
                instr_valid = 1'b1;
                issued      = issued + 1;
            end
        end
        @(negedge clock);
        instr_valid = 1'b0;
        wait_cyc    = 0;
        while (pending != 0 && wait_cyc < 50) begin
            @(negedge clock);
            wait_cyc = wait_cyc + 1;
        end
        if (pending != 0) begin
            $display("timeout with %0d results still outstanding", pending);
            timed_out = 1'b1;
        end
        repeat (4) @(negedge clock);
        $display("checked %0d results, %0d errors", checked, errors);
        if (errors == 0 && !timed_out && checked > 300) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* all.f */
verilog/exu_pkg.sv
verilog/int_decode.sv
verilog/regfile.sv
verilog/alu.sv
verilog/int_exu.sv
test/int_exu_check.sv
test/int_exu_assert.sv
test/int_exu_tb.sv

/* run.sh */
#!/bin/sh
# Build and run the int_exu testbench with Verilator.
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f all.f --top-module int_exu_tb -o sim_int_exu
if [ $? -ne 0 ]; then
    echo "compile failed"
    exit 1
fi

out=$(./obj_dir/sim_int_exu)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$out" | grep -q "All tests passed"; then
    exit 0
fi
exit 1
